// ==== files.f ====
+incdir+include
verilog/rvPkg.sv
verilog/decodeIf.sv
verilog/idu.sv
verilog/alu.sv
verilog/regFile.sv
verilog/controller.sv
verilog/rvCore.sv
dv/rvCore_assertions.sv
dv/rvCoreTb.sv

// ==== Bender.yml ====
package:
  name: rv_core

export_include_dirs:
  - include

sources:
  - verilog/rvPkg.sv
  - verilog/decodeIf.sv
  - verilog/idu.sv
  - verilog/alu.sv
  - verilog/regFile.sv
  - verilog/controller.sv
  - verilog/rvCore.sv
  - target: test
    files:
      - dv/rvCore_assertions.sv
      - dv/rvCoreTb.sv

// ==== dv/rvCoreTb.sv ====
// random-program testbench for rvCore that checks fetches and bus writes against an ISA model
`include "rvOpcodes.svh"

module rvCoreTb;

  localparam logic [31:0] resetPc     = 32'h0;
  localparam int          memWords    = 512;
  localparam int          bodyItems   = 24;
  localparam int          haltTimeout = 20000;
  localparam int          idleCycles  = 20;

  logic        clk = 1'b0;
  logic        rst;
  logic [31:0] wbAdr;
  logic [31:0] wbDatW;
  logic [31:0] wbDatR;
  logic [3:0]  wbSel;
  logic        wbWe;
  logic        wbCyc;
  logic        wbStb;
  logic        wbAck;
  logic        halted;

  integer      seed = 32'h680c;
  int          errors = 0;
  int          checks = 0;
  logic [31:0] mem [memWords];
  logic [31:0] modelMem [memWords];
  logic [31:0] xr [32];
  logic [31:0] pcTrace [$];
  logic [31:0] expAdr [$];
  logic [3:0]  expSel [$];
  logic [31:0] expDat [$];
  int          fetchIdx = 0;
  int          storeIdx = 0;
  int          waitLeft = 0;
  logic        pending = 1'b0;
  logic        reqOpen = 1'b0;
  logic [31:0] reqAdr;
  logic [31:0] reqDat;
  logic [3:0]  reqSel;
  logic        reqWe;

  rvCore #(
    .resetPc (resetPc)
  ) UUT (
    .clk    (clk),
    .rst    (rst),
    .wbAdr  (wbAdr),
    .wbDatW (wbDatW),
    .wbDatR (wbDatR),
    .wbSel  (wbSel),
    .wbWe   (wbWe),
    .wbCyc  (wbCyc),
    .wbStb  (wbStb),
    .wbAck  (wbAck),
    .halted (halted)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] nextRand();
    return $random(seed);
  endfunction

  // pattern over the whole word index
  function automatic logic [31:0] fillWord(input int idx);
    return (idx * 32'h0100_0193) ^ 32'h5bd1_e995;
  endfunction

  function automatic logic [31:0] laneMask(input logic [3:0] sel);
    return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
  endfunction

  function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, `OP_REG};
  endfunction

  function automatic logic [31:0] encI(input logic [6:0] opc, input logic [11:0] imm,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], `OP_STORE};
  endfunction

  function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OP_BRANCH};
  endfunction

  function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, `OP_LUI};
  endfunction

  function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OP_JAL};
  endfunction

  // integer result by funct3 with alt taken from instruction bit 30
  function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {31'b0, $signed(a) < $signed(b)};
      3'b011:  return {31'b0, a < b};
      3'b100:  return a ^ b;
      3'b101:  return alt ? $signed(a) >>> b[4:0] : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic expectEq(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("** Error [%0t] %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // x31 holds the data base 1024 and every other register gets a value first
  task automatic buildProgram();
    logic [31:0] r;
    logic [31:0] prog [$];
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [6:0]  off;
    int          kind;
    prog.push_back(encI(`OP_IMM, 12'd1024, 5'd0, 3'b000, 5'd31));
    for (int i = 1; i < 31; i++) begin
      r = nextRand();
      prog.push_back(encI(`OP_IMM, r[11:0], 5'd0, 3'b000, 5'(i)));
    end
    for (int k = 0; k < bodyItems; k++) begin
      r    = nextRand();
      kind = r[15:0] % 7;
      rd   = 5'd1 + 5'(r[20:16] % 30);
      rs1  = r[25:21];
      rs2  = r[30:26];
      r    = nextRand();
      case (kind)
        0: prog.push_back(encU(r[19:0], rd));
        1: prog.push_back(encI(`OP_IMM, r[11:0], rs1, 3'b000, rd));
        2, 3: begin
          f3 = r[2:0];
          f7 = (r[3] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
          prog.push_back(encR(f7, rs2, rs1, f3, rd));
        end
        4: begin
          f3  = 3'(r[7:4] % 3);
          off = r[14:8] & ~((7'd1 << f3[1:0]) - 7'd1);
          prog.push_back(encS({5'd0, off}, rs2, 5'd31, f3));
        end
        5: begin
          case (r[7:4] % 5)
            0:       f3 = 3'b000;
            1:       f3 = 3'b100;
            2:       f3 = 3'b001;
            3:       f3 = 3'b101;
            default: f3 = 3'b010;
          endcase
          off = r[14:8] & ~((7'd1 << f3[1:0]) - 7'd1);
          prog.push_back(encI(`OP_LOAD, {5'd0, off}, 5'd31, f3, rd));
        end
        default: begin
          // forward skip over one addi
          if (r[0]) begin
            case (r[2:1])
              2'd0:    f3 = 3'b000;
              2'd1:    f3 = 3'b001;
              2'd2:    f3 = 3'b100;
              default: f3 = 3'b111;
            endcase
            prog.push_back(encB(13'd8, r[3] ? rs1 : rs2, rs1, f3));
          end else begin
            prog.push_back(encJ(21'd8, rd));
          end
          r = nextRand();
          prog.push_back(encI(`OP_IMM, r[11:0], r[16:12], 3'b000, 5'd1 + 5'(r[21:17] % 30)));
        end
      endcase
    end
    // register dump above the random store window
    for (int i = 0; i < 32; i++) begin
      prog.push_back(encS(12'(128 + 4 * i), 5'(i), 5'd31, 3'b010));
    end
    prog.push_back(`INST_EBREAK);
    for (int i = 0; i < memWords; i++) begin
      mem[i] = fillWord(i);
    end
    foreach (prog[i]) begin
      mem[i] = prog[i];
    end
    modelMem = mem;
  endtask

  task automatic runModel();
    logic [31:0] pc;
    logic [31:0] nextPc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] addr;
    logic [31:0] word;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immJ;
    logic [3:0]  sel;
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic        wr;
    logic        taken;
    int          steps;
    pc    = resetPc;
    steps = 0;
    foreach (xr[i]) begin
      xr[i] = '0;
    end
    while (steps < 1000) begin
      pcTrace.push_back(pc);
      ins = modelMem[pc[10:2]];
      if (ins == `INST_EBREAK) break;
      opc    = ins[6:0];
      rd     = ins[11:7];
      f3     = ins[14:12];
      a      = xr[ins[19:15]];
      b      = xr[ins[24:20]];
      immI   = {{20{ins[31]}}, ins[31:20]};
      immS   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      immB   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      immJ   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      nextPc = pc + 4;
      wr     = 1'b1;
      res    = '0;
      case (opc)
        `OP_LUI: res = {ins[31:12], 12'h0};
        `OP_IMM: res = aluRef(f3, f3 == 3'b101 && ins[30], a, immI);
        `OP_REG: res = aluRef(f3, ins[30], a, b);
        `OP_JAL: begin
          res    = pc + 4;
          nextPc = pc + immJ;
        end
        `OP_LOAD: begin
          addr = a + immI;
          word = modelMem[addr[10:2]] >> {addr[1:0], 3'b000};
          case (f3)
            3'b000:  res = {{24{word[7]}}, word[7:0]};
            3'b100:  res = {24'h0, word[7:0]};
            3'b001:  res = {{16{word[15]}}, word[15:0]};
            3'b101:  res = {16'h0, word[15:0]};
            default: res = word;
          endcase
        end
        `OP_STORE: begin
          wr   = 1'b0;
          addr = a + immS;
          sel  = (f3 == 3'b000) ? 4'b0001 : (f3 == 3'b001) ? 4'b0011 : 4'b1111;
          sel  = sel << addr[1:0];
          word = (b << {addr[1:0], 3'b000}) & laneMask(sel);
          expAdr.push_back({addr[31:2], 2'b00});
          expSel.push_back(sel);
          expDat.push_back(word);
          modelMem[addr[10:2]] = (modelMem[addr[10:2]] & ~laneMask(sel)) | word;
        end
        `OP_BRANCH: begin
          wr = 1'b0;
          case (f3)
            3'b000:  taken = (a == b);
            3'b001:  taken = (a != b);
            3'b100:  taken = $signed(a) < $signed(b);
            3'b101:  taken = $signed(a) >= $signed(b);
            3'b110:  taken = a < b;
            default: taken = a >= b;
          endcase
          if (taken) nextPc = pc + immB;
        end
        default: wr = 1'b0;
      endcase
      if (wr && rd != 5'd0) xr[rd] = res;
      pc = nextPc;
      steps++;
    end
  endtask

  // one acked access with the program below 0x200 and data from 0x400
  task automatic serveAccess();
    int idx;
    idx = wbAdr[10:2];
    checks++;
    assert (wbAdr < 32'h800) else begin
      errors++;
      $display("bus access at %h lies outside the test memory", wbAdr);
    end
    if (wbWe) begin
      checks++;
      assert (storeIdx < expAdr.size()) else begin
        errors++;
        $display("bus write at %h comes after the last store the model made", wbAdr);
      end
      if (storeIdx < expAdr.size()) begin
        expectEq(wbAdr, expAdr[storeIdx], "store address");
        expectEq(32'(wbSel), 32'(expSel[storeIdx]), "store select");
        expectEq(wbDatW & laneMask(wbSel), expDat[storeIdx], "store data");
      end
      storeIdx++;
      mem[idx] = (mem[idx] & ~laneMask(wbSel)) | (wbDatW & laneMask(wbSel));
    end else begin
      wbDatR <= mem[idx];
      if (wbAdr < 32'h200) begin
        expectEq(32'(wbSel), 32'hf, "fetch select");
        checks++;
        assert (fetchIdx < pcTrace.size()) else begin
          errors++;
          $display("fetch at %h comes after the end of the model's pc trace", wbAdr);
        end
        if (fetchIdx < pcTrace.size()) begin
          expectEq(wbAdr, pcTrace[fetchIdx], "fetch address");
        end
        fetchIdx++;
      end
    end
  endtask

  // Wishbone slave with 0 to 3 wait states
  always @(negedge clk) begin
    if (rst) begin
      wbAck   <= 1'b0;
      pending  = 1'b0;
    end else if (wbAck) begin
      wbAck <= 1'b0;
    end else if (wbCyc && wbStb) begin
      if (!pending) begin
        pending  = 1'b1;
        waitLeft = nextRand() & 3;
      end
      if (waitLeft == 0) begin
        pending = 1'b0;
        serveAccess();
        wbAck <= 1'b1;
      end else begin
        waitLeft--;
      end
    end
  end

  // stable request until ack, no strobe outside a cycle and no cycle once halted
  always @(negedge clk) begin
    if (rst) begin
      reqOpen = 1'b0;
    end else begin
      checks++;
      assert (wbCyc || !wbStb) else begin
        errors++;
        $display("wbStb is high without wbCyc at time %0t", $time);
      end
      checks++;
      assert (!(halted && wbCyc)) else begin
        errors++;
        $display("a bus cycle is open after halted at time %0t", $time);
      end
      if (wbCyc && wbStb) begin
        if (reqOpen) begin
          checks++;
          assert (wbAdr === reqAdr && wbSel === reqSel && wbWe === reqWe
                  && (!reqWe || wbDatW === reqDat)) else begin
            errors++;
            $display("bus request at %h changed before wbAck at time %0t", reqAdr, $time);
          end
        end else begin
          reqOpen = 1'b1;
          reqAdr  = wbAdr;
          reqDat  = wbDatW;
          reqSel  = wbSel;
          reqWe   = wbWe;
        end
      end else begin
        reqOpen = 1'b0;
      end
    end
  end

  initial begin
    int cycles;
    rst    = 1'b1;
    wbAck  = 1'b0;
    wbDatR = '0;
    buildProgram();
    runModel();
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    expectEq(wbCyc, 0, "wbCyc after reset");
    expectEq(wbStb, 0, "wbStb after reset");
    expectEq(wbWe, 0, "wbWe after reset");
    expectEq(halted, 0, "halted after reset");
    @(negedge clk);
    expectEq(wbCyc, 1, "first request wbCyc");
    expectEq(wbStb, 1, "first request wbStb");
    expectEq(wbWe, 0, "first request wbWe");
    expectEq(wbAdr, resetPc, "first request address");
    expectEq(32'(wbSel), 32'hf, "first request select");
    cycles = 0;
    while (!halted && cycles < haltTimeout) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted) begin
      errors++;
      $display("timeout, halted did not rise within %0d cycles", haltTimeout);
    end else begin
      expectEq(storeIdx, expAdr.size(), "store count");
      expectEq(fetchIdx, pcTrace.size(), "fetch count");
      for (int i = 0; i < idleCycles; i++) begin
        @(negedge clk);
        expectEq(wbCyc, 0, "wbCyc after halt");
      end
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== dv/rvCore_assertions.sv ====
// Wishbone protocol and halt checks bound to every rvCore instance
module rvCoreAssertions (
  input logic        clk,
  input logic        rst,
  input logic [31:0] wbAdr,
  input logic [31:0] wbDatW,
  input logic [3:0]  wbSel,
  input logic        wbWe,
  input logic        wbCyc,
  input logic        wbStb,
  input logic        wbAck,
  input logic        halted
);

  stbInCyc: assert property (@(posedge clk) disable iff (rst) wbStb |-> wbCyc)
    else $error("wbStb high without wbCyc");

  // request fields hold until the slave acks and write data only matters for writes
  reqStable: assert property (@(posedge clk) disable iff (rst)
    wbCyc && wbStb && !wbAck |=> $stable(wbAdr) && $stable(wbSel) && $stable(wbWe)
      && (!wbWe || $stable(wbDatW)))
    else $error("Wishbone request changed before wbAck");

  haltNoBus: assert property (@(posedge clk) disable iff (rst) halted |-> !wbCyc)
    else $error("bus cycle after halted");

endmodule

bind rvCore rvCoreAssertions uAssertions (.*);

// ==== verilog/rvCore.sv ====
// top level of the multicycle RV32I core, plain Wishbone master ports and a halt flag
module rvCore #(
  parameter logic [31:0] resetPc = 32'h0
) (
  input  logic                   clk,
  input  logic                   rst,
  output logic [rvPkg::xlen-1:0] wbAdr,
  output logic [rvPkg::xlen-1:0] wbDatW,
  input  logic [rvPkg::xlen-1:0] wbDatR,
  output logic [3:0]             wbSel,
  output logic                   wbWe,
  output logic                   wbCyc,
  output logic                   wbStb,
  input  logic                   wbAck,
  output logic                   halted
);
  import rvPkg::*;

  logic [xlen-1:0] instr;
  logic [xlen-1:0] aluA, aluB, aluY;
  logic [xlen-1:0] rd1, rd2;
  logic [xlen-1:0] rfWd;
  logic [4:0]      rfRd;
  logic            rfWe;

  decodeIf dIf ();

  idu uIdu (
    .inst (instr),
    .d    (dIf.dec)
  );

  alu uAlu (
    .op (dIf.aluOp),
    .a  (aluA),
    .b  (aluB),
    .y  (aluY)
  );

  regFile uRegFile (
    .clk (clk),
    .rs1 (dIf.rs1),
    .rs2 (dIf.rs2),
    .rd1 (rd1),
    .rd2 (rd2),
    .we  (rfWe),
    .rd  (rfRd),
    .wd  (rfWd)
  );

  controller #(
    .resetPc (resetPc)
  ) uCtrl (
    .clk    (clk),
    .rst    (rst),
    .instr  (instr),
    .d      (dIf.user),
    .aluA   (aluA),
    .aluB   (aluB),
    .aluY   (aluY),
    .we     (rfWe),
    .rd     (rfRd),
    .wd     (rfWd),
    .rd1    (rd1),
    .rd2    (rd2),
    .wbAdr  (wbAdr),
    .wbDatW (wbDatW),
    .wbDatR (wbDatR),
    .wbSel  (wbSel),
    .wbWe   (wbWe),
    .wbCyc  (wbCyc),
    .wbStb  (wbStb),
    .wbAck  (wbAck),
    .halted (halted)
  );

endmodule

// ==== verilog/controller.sv ====
// multicycle control for the core: fetch, execute and memory FSM, pc, and the Wishbone master
module controller #(
  parameter logic [31:0] resetPc = 32'h0
) (
  input  logic                   clk,
  input  logic                   rst,
  output logic [rvPkg::xlen-1:0] instr,
  decodeIf.user                  d,
  output logic [rvPkg::xlen-1:0] aluA,
  output logic [rvPkg::xlen-1:0] aluB,
  input  logic [rvPkg::xlen-1:0] aluY,
  output logic                   we,
  output logic [4:0]             rd,
  output logic [rvPkg::xlen-1:0] wd,
  input  logic [rvPkg::xlen-1:0] rd1,
  input  logic [rvPkg::xlen-1:0] rd2,
  output logic [rvPkg::xlen-1:0] wbAdr,
  output logic [rvPkg::xlen-1:0] wbDatW,
  input  logic [rvPkg::xlen-1:0] wbDatR,
  output logic [3:0]             wbSel,
  output logic                   wbWe,
  output logic                   wbCyc,
  output logic                   wbStb,
  input  logic                   wbAck,
  output logic                   halted
);
  import rvPkg::*;

  typedef enum logic [2:0] {
    FETCH,
    EXEC,
    MEM,
    WB,
    HALT
  } stateE;

  stateE           state;
  logic [xlen-1:0] pc;
  logic [xlen-1:0] pcPlus4;
  logic [xlen-1:0] pcNext;
  logic [xlen-1:0] memData;
  logic [xlen-1:0] loadShifted;
  logic [xlen-1:0] loadData;
  logic [1:0]      byteOff;
  logic            taken;

  assign aluA    = d.src1Pc ? pc : rd1;
  assign aluB    = d.src2Imm ? d.imm : rd2;
  assign pcPlus4 = pc + 32'd4;
  // address stays valid through MEM and WB since instr and rs1 do not change
  assign byteOff = aluY[1:0];

  always_comb begin
    case (d.brFunct)
      3'b000:         taken = (aluY == '0);
      3'b001:         taken = (aluY != '0);
      3'b100, 3'b110: taken = aluY[0];
      3'b101, 3'b111: taken = !aluY[0];
      default:        taken = 1'b1;
    endcase
  end

  always_comb begin
    case (d.pcOp)
      PC_BRJ:  pcNext = taken ? pc + d.imm : pcPlus4;
      PC_REG:  pcNext = {aluY[xlen-1:1], 1'b0};
      default: pcNext = pcPlus4;
    endcase
  end

  // load alignment and extension
  assign loadShifted = memData >> {byteOff, 3'b000};
  always_comb begin
    case (d.loadSize)
      2'b00:   loadData = {{24{d.loadSigned & loadShifted[7]}}, loadShifted[7:0]};
      2'b01:   loadData = {{16{d.loadSigned & loadShifted[15]}}, loadShifted[15:0]};
      default: loadData = loadShifted;
    endcase
  end

  // register write, loads wait for WB
  assign we = d.regWrite && ((state == EXEC && !d.isLoad) || state == WB);
  assign rd = d.rd;
  always_comb begin
    case (d.wdOp)
      WD_MEM:  wd = loadData;
      WD_LINK: wd = pcPlus4;
      default: wd = aluY;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= FETCH;
      pc     <= resetPc;
      wbCyc  <= 1'b0;
      wbStb  <= 1'b0;
      wbWe   <= 1'b0;
      halted <= 1'b0;
    end else begin
      case (state)
        FETCH: begin
          if (!wbCyc) begin
            wbCyc <= 1'b1;
            wbStb <= 1'b1;
            wbWe  <= 1'b0;
          end else if (wbAck) begin
            wbCyc <= 1'b0;
            wbStb <= 1'b0;
            state <= EXEC;
          end
        end
        EXEC: begin
          pc <= pcNext;
          if (d.ebreak) begin
            halted <= 1'b1;
            state  <= HALT;
          end else if (d.isLoad || d.isStore) begin
            wbCyc <= 1'b1;
            wbStb <= 1'b1;
            wbWe  <= d.isStore;
            state <= MEM;
          end else begin
            state <= FETCH;
          end
        end
        MEM: begin
          if (wbAck) begin
            wbCyc <= 1'b0;
            wbStb <= 1'b0;
            wbWe  <= 1'b0;
            state <= d.isLoad ? WB : FETCH;
          end
        end
        WB:      state <= FETCH;
        default: state <= HALT;
      endcase
    end
  end

  // bus payload and instruction/data capture
  always_ff @(posedge clk) begin
    if (state == FETCH && !wbCyc) begin
      wbAdr <= pc;
      wbSel <= 4'b1111;
    end
    if (state == FETCH && wbCyc && wbAck) begin
      instr <= wbDatR;
    end
    if (state == EXEC) begin
      wbAdr  <= {aluY[xlen-1:2], 2'b00};
      wbSel  <= d.isStore ? d.storeSel << byteOff : 4'b1111;
      wbDatW <= rd2 << {byteOff, 3'b000};
    end
    if (state == MEM && wbAck) begin
      memData <= wbDatR;
    end
  end

endmodule

// ==== verilog/regFile.sv ====
// 32-entry integer register file, two combinational reads and one clocked write
module regFile (
  input  logic                   clk,
  input  logic [4:0]             rs1,
  input  logic [4:0]             rs2,
  output logic [rvPkg::xlen-1:0] rd1,
  output logic [rvPkg::xlen-1:0] rd2,
  input  logic                   we,
  input  logic [4:0]             rd,
  input  logic [rvPkg::xlen-1:0] wd
);
  import rvPkg::*;

  logic [xlen-1:0] regs [32];

  // x0 reads as zero whatever was written
  assign rd1 = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rd2 = (rs2 == 5'd0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (we && rd != 5'd0) begin
      regs[rd] <= wd;
    end
  end

endmodule

// ==== verilog/alu.sv ====
// combinational integer ALU, one result per rvPkg operation
module alu (
  input  rvPkg::aluOpE           op,
  input  logic [rvPkg::xlen-1:0] a,
  input  logic [rvPkg::xlen-1:0] b,
  output logic [rvPkg::xlen-1:0] y
);
  import rvPkg::*;

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      ALU_ADD:  y = a + b;
      ALU_SUB:  y = a - b;
      ALU_AND:  y = a & b;
      ALU_OR:   y = a | b;
      ALU_XOR:  y = a ^ b;
      ALU_SL:   y = a << shamt;
      ALU_SR:   y = a >> shamt;
      ALU_SSR:  y = $signed(a) >>> shamt;
      ALU_SLES: y = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
      ALU_ULES: y = {{(xlen-1){1'b0}}, a < b};
      // lui passes the immediate
      ALU_IMM:  y = b;
      default:  y = '0;
    endcase
  end

endmodule

// ==== verilog/idu.sv ====
// combinational RV32I decoder, turns the fetched word into the control bundle for the controller
`include "rvOpcodes.svh"

module idu (
  input  logic [rvPkg::xlen-1:0] inst,
  decodeIf.dec                   d
);
  import rvPkg::*;

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  instTypeE        instType;
  aluOpE           arithOp;
  logic [xlen-1:0] immI, immU, immS, immJ, immB;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];

  assign immI = {{20{inst[31]}}, inst[31:20]};
  assign immU = {inst[31:12], 12'b0};
  assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign immJ = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  assign immB = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

  // format from the major opcode, unknown ones fall back to I
  always_comb begin
    case (opcode)
      `OP_LUI, `OP_AUIPC:          instType = TYPE_U;
      `OP_IMM, `OP_LOAD, `OP_JALR: instType = TYPE_I;
      `OP_JAL:                     instType = TYPE_J;
      `OP_STORE:                   instType = TYPE_S;
      `OP_REG:                     instType = TYPE_R;
      `OP_BRANCH:                  instType = TYPE_B;
      default:                     instType = TYPE_I;
    endcase
  end

  // shared by OP-IMM and OP, bit 30 picks sub only for register ops
  always_comb begin
    case (funct3)
      3'b000:  arithOp = (opcode == `OP_REG && inst[30]) ? ALU_SUB : ALU_ADD;
      3'b001:  arithOp = ALU_SL;
      3'b010:  arithOp = ALU_SLES;
      3'b011:  arithOp = ALU_ULES;
      3'b100:  arithOp = ALU_XOR;
      3'b101:  arithOp = inst[30] ? ALU_SSR : ALU_SR;
      3'b110:  arithOp = ALU_OR;
      default: arithOp = ALU_AND;
    endcase
  end

  always_comb begin
    d.rs1 = inst[19:15];
    d.rs2 = inst[24:20];
    d.rd  = inst[11:7];

    case (instType)
      TYPE_U:  d.imm = immU;
      TYPE_S:  d.imm = immS;
      TYPE_J:  d.imm = immJ;
      TYPE_B:  d.imm = immB;
      TYPE_R:  d.imm = '0;
      default: d.imm = immI;
    endcase

    case (opcode)
      `OP_IMM, `OP_REG: d.aluOp = arithOp;
      `OP_LUI:          d.aluOp = ALU_IMM;
      `OP_BRANCH: begin
        case (funct3[2:1])
          2'b10:   d.aluOp = ALU_SLES;
          2'b11:   d.aluOp = ALU_ULES;
          default: d.aluOp = ALU_SUB;
        endcase
      end
      default:          d.aluOp = ALU_ADD;
    endcase

    d.src1Pc  = (opcode == `OP_AUIPC) || (opcode == `OP_JAL);
    d.src2Imm = (instType != TYPE_R) && (instType != TYPE_B);

    case (opcode)
      `OP_BRANCH, `OP_JAL: d.pcOp = PC_BRJ;
      `OP_JALR:            d.pcOp = PC_REG;
      default:             d.pcOp = PC_SEQ;
    endcase

    case (opcode)
      `OP_LOAD:            d.wdOp = WD_MEM;
      `OP_JAL, `OP_JALR:   d.wdOp = WD_LINK;
      default:             d.wdOp = WD_ALU;
    endcase

    // 010 is no branch condition, the controller treats it as always taken
    d.brFunct = (opcode == `OP_BRANCH) ? funct3 : 3'b010;

    d.isLoad   = (opcode == `OP_LOAD);
    d.isStore  = (instType == TYPE_S);
    d.regWrite = (instType != TYPE_S) && (instType != TYPE_B);

    case (funct3[1:0])
      2'b00:   d.storeSel = 4'b0001;
      2'b01:   d.storeSel = 4'b0011;
      default: d.storeSel = 4'b1111;
    endcase
    d.loadSize   = funct3[1:0];
    d.loadSigned = !funct3[2];

    d.ebreak = (inst == `INST_EBREAK);
  end

endmodule

// ==== verilog/decodeIf.sv ====
// decoded control bundle, driven by the decoder and read by the controller and ALU
interface decodeIf;
  import rvPkg::*;

  logic [4:0]      rs1;
  logic [4:0]      rs2;
  logic [4:0]      rd;
  logic [xlen-1:0] imm;
  aluOpE           aluOp;
  logic            src1Pc;
  logic            src2Imm;
  pcOpE            pcOp;
  wdOpE            wdOp;
  logic [2:0]      brFunct;
  logic            isLoad;
  logic            isStore;
  logic [3:0]      storeSel;
  // 0 byte, 1 half, 2 word
  logic [1:0]      loadSize;
  logic            loadSigned;
  logic            regWrite;
  logic            ebreak;

  modport dec (
    output rs1, rs2, rd, imm, aluOp, src1Pc, src2Imm, pcOp, wdOp, brFunct,
    output isLoad, isStore, storeSel, loadSize, loadSigned, regWrite, ebreak
  );

  modport user (
    input rs1, rs2, rd, imm, aluOp, src1Pc, src2Imm, pcOp, wdOp, brFunct,
    input isLoad, isStore, storeSel, loadSize, loadSigned, regWrite, ebreak
  );

endinterface

// ==== verilog/rvPkg.sv ====
// shared types for the RV32I core, imported by the decoder, ALU, controller and top level
package rvPkg;

  localparam int xlen = 32;

  // instruction formats
  typedef enum logic [2:0] {
    TYPE_I,
    TYPE_U,
    TYPE_S,
    TYPE_J,
    TYPE_B,
    TYPE_R
  } instTypeE;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SL,
    ALU_SR,
    ALU_SSR,
    ALU_SLES,
    ALU_ULES,
    ALU_IMM
  } aluOpE;

  // next pc source
  typedef enum logic [1:0] {
    PC_SEQ,
    PC_BRJ,
    PC_REG
  } pcOpE;

  // register write-back source
  typedef enum logic [1:0] {
    WD_ALU,
    WD_MEM,
    WD_LINK
  } wdOpE;

endpackage

// ==== include/rvOpcodes.svh ====
// major opcode values and the ebreak word, included wherever RV32I words are built or decoded
`ifndef RV_OPCODES_SVH
`define RV_OPCODES_SVH

`define OP_LUI     7'b0110111
`define OP_AUIPC   7'b0010111
`define OP_IMM     7'b0010011
`define OP_LOAD    7'b0000011
`define OP_JALR    7'b1100111
`define OP_JAL     7'b1101111
`define OP_STORE   7'b0100011
`define OP_REG     7'b0110011
`define OP_BRANCH  7'b1100011

`define INST_EBREAK 32'h00100073

`endif
